// ==== bench/board_checker.sv ====
`timescale 1ns/1ps

/*
  Scoreboard for board_inputs. Expected stick outputs only hold once the
  inputs have been stable for at least 4 clocks. soft_rst is compared every clock.
*/
module board_checker #(
    parameter int BUTTONS           = 2,
    parameter int INPUTS_ACTIVE_LOW = 1
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  board_pkg::board_joy_t board_joy [board_pkg::PLAYERS],
    input  board_pkg::host_keys_t keys,
    input  logic                  en4way,
    input  logic                  rot,
    input  logic                  flip,
    input  logic                  osd_pause,
    input  logic                  downloading,
    input  board_pkg::game_joy_t  game_joy  [board_pkg::PLAYERS],
    input  logic [3:0]            game_coin,
    input  logic [3:0]            game_start,
    input  logic                  game_pause,
    input  logic                  soft_rst,
    input  logic                  game_service,
    input  logic [3:0]            gfx_en,
    input  logic                  check_req,
    input  int                    test_num,
    output logic                  check_ack,
    output int                    checks_passed,
    output int                    checks_failed
);
    import board_pkg::*;

    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);
    localparam bit INV       = (INPUTS_ACTIVE_LOW != 0);

    typedef struct packed {
        game_joy_t [PLAYERS-1:0] joy;
        logic [3:0]              coin;
        logic [3:0]              start;
    } expect_t;

    logic [3:0] held_ref [PLAYERS];
    logic [3:0] dir_ref  [PLAYERS];
    host_keys_t keys_prev;
    logic       stick_pause_prev;
    logic       osd_prev;
    logic       pause_ref;
    logic       soft_rst_ref;
    logic [3:0] gfx_ref;
    logic       service_ref;
    logic       pulse_err;
    int         check_idx;

    // Next held direction of a 4-way stick
    function automatic logic [3:0] filter_next(input logic [3:0] held, input logic [3:0] dir);
        if ($countones(dir) == 1) begin
            return dir;
        end
        if (dir == 4'b0000 || (held & dir) == 4'b0000) begin
            return 4'b0000;
        end
        return held;
    endfunction

    function automatic logic [3:0] rotate_ref(input logic [3:0] d, input logic r, input logic f);
        logic up;
        logic down;
        logic left;
        logic right;
        up    = d[3];
        down  = d[2];
        left  = d[1];
        right = d[0];
        if (r && f) begin
            return {left, right, down, up};
        end else if (r) begin
            return {right, left, up, down};
        end
        return d;
    endfunction

    // Expected game sticks, coin and start
    function automatic expect_t ref_outputs(
        input board_joy_t sticks [PLAYERS],
        input logic [3:0] dirs   [PLAYERS],
        input logic       r,
        input logic       f,
        input logic       inv
    );
        expect_t     e;
        logic [15:0] word;
        for (int p = 0; p < PLAYERS; p++) begin
            word           = sticks[p];
            e.joy[p].btn   = sticks[p].btn[5:0];
            e.joy[p].dir   = rotate_ref(dirs[p], r, f);
            e.coin[p]      = word[COIN_BIT];
            e.start[p]     = word[START_BIT];
        end
        if (inv) begin
            e = ~e;
        end
        return e;
    endfunction

    function automatic int mismatch(input string name, input logic [15:0] expected,
                                    input logic [15:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h got %h", name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // Model of the filters and the control block
    always @(posedge clk_sys) begin : model
        logic       stick_pause;
        logic [3:0] nxt;
        stick_pause      = board_joy[0][PAUSE_BIT] | board_joy[1][PAUSE_BIT];
        keys_prev        <= keys;
        stick_pause_prev <= stick_pause;
        osd_prev         <= osd_pause;
        if (rst) begin
            for (int p = 0; p < PLAYERS; p++) begin
                held_ref[p] <= 4'b0000;
                dir_ref[p]  <= 4'b0000;
            end
            pause_ref    <= 1'b0;
            soft_rst_ref <= 1'b0;
            gfx_ref      <= 4'hf;
            service_ref  <= INV;
        end else begin
            for (int p = 0; p < PLAYERS; p++) begin
                nxt         = filter_next(held_ref[p], board_joy[p].dir);
                held_ref[p] <= en4way ? nxt : 4'b0000;
                dir_ref[p]  <= en4way ? nxt : board_joy[p].dir;
            end
            if (downloading) begin
                pause_ref <= 1'b0;
            end else if (osd_pause != osd_prev) begin
                pause_ref <= osd_pause;
            end else if ((keys.pause && !keys_prev.pause) || (stick_pause && !stick_pause_prev)) begin
                pause_ref <= !pause_ref;
            end
            soft_rst_ref <= keys.reset && !keys_prev.reset;
            gfx_ref      <= gfx_ref ^ (keys.gfx & ~keys_prev.gfx);
            service_ref  <= keys.service ^ INV;
        end
    end

    always @(posedge clk_sys) begin : compare
        expect_t exp_v;
        int      errs;
        logic    soft_bad;
        soft_bad = !rst && (soft_rst !== soft_rst_ref);
        if (soft_bad) begin
            $display("error soft_rst expected %h got %h", soft_rst_ref, soft_rst);
        end
        if (rst) begin
            check_ack     <= 1'b0;
            pulse_err     <= 1'b0;
            checks_passed <= 0;
            checks_failed <= 0;
            check_idx     <= 0;
        end else if (check_req && !check_ack) begin
            exp_v = ref_outputs(board_joy, dir_ref, rot, flip, INV);
            errs  = (pulse_err || soft_bad) ? 1 : 0;
            for (int p = 0; p < PLAYERS; p++) begin
                errs += mismatch($sformatf("game_joy[%0d]", p), exp_v.joy[p], game_joy[p]);
            end
            errs += mismatch("game_coin", exp_v.coin, game_coin);
            errs += mismatch("game_start", exp_v.start, game_start);
            errs += mismatch("game_pause", pause_ref, game_pause);
            errs += mismatch("gfx_en", gfx_ref, gfx_en);
            errs += mismatch("game_service", service_ref, game_service);
            if (errs == 0) begin
                $display("test %0d check %0d passed", test_num, check_idx + 1);
                checks_passed <= checks_passed + 1;
            end else begin
                $display("test %0d check %0d failed, %0d mismatches", test_num, check_idx + 1, errs);
                checks_failed <= checks_failed + 1;
            end
            check_idx <= check_idx + 1;
            check_ack <= 1'b1;
            pulse_err <= 1'b0;
        end else begin
            check_ack <= 1'b0;
            if (soft_bad) begin
                pulse_err <= 1'b1;
            end
        end
    end

endmodule

// ==== bench/tb_board_inputs.sv ====
`timescale 1ns/1ps

/*
  Testbench for board_inputs with default parameters (active-low game side).
  Inputs change on falling edges and are held 4 clocks before each check.
*/
module tb_board_inputs;
    import board_pkg::*;

    localparam int BUTTONS           = 2;
    localparam int INPUTS_ACTIVE_LOW = 1;
    localparam int PAUSE_BIT         = 8 + (BUTTONS - 2);
    localparam int ACK_TIMEOUT       = 8;
    localparam int PULSE_WINDOW      = 8;

    logic       clk_sys;
    logic       rst;
    board_joy_t board_joy [PLAYERS];
    host_keys_t keys;
    logic       en4way;
    logic       rot;
    logic       flip;
    logic       osd_pause;
    logic       downloading;
    game_joy_t  game_joy [PLAYERS];
    logic [3:0] game_coin;
    logic [3:0] game_start;
    logic       game_pause;
    logic       soft_rst;
    logic       game_service;
    logic [3:0] gfx_en;
    logic       check_req;
    int         test_num;
    logic       check_ack;
    int         checks_passed;
    int         checks_failed;
    int         bench_fails;

    board_inputs DUT (.*);

    board_checker #(
        .BUTTONS           ( BUTTONS           ),
        .INPUTS_ACTIVE_LOW ( INPUTS_ACTIVE_LOW )
    ) u_board_checker (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    task automatic settle(input int cycles);
        repeat (cycles) @(negedge clk_sys);
    endtask

    // Ask the checker to compare and wait for its answer
    task automatic request_check(input int num);
        bit got;
        got       = 1'b0;
        test_num  = num;
        check_req = 1'b1;
        for (int n = 0; n < ACK_TIMEOUT && !got; n++) begin
            @(negedge clk_sys);
            got = check_ack;
        end
        check_req = 1'b0;
        if (!got) begin
            $display("test %0d: checker gave no answer within %0d cycles", num, ACK_TIMEOUT);
            bench_fails++;
        end
    endtask

    task automatic random_sticks();
        logic [31:0] word;
        for (int p = 0; p < PLAYERS; p++) begin
            word         = $urandom;
            board_joy[p] = word[15:0];
        end
    endtask

    // One reset key press must give a single one-clock pulse
    task automatic soft_reset_pulse();
        int high_cycles;
        high_cycles = 0;
        keys.reset  = 1'b1;
        for (int n = 0; n < PULSE_WINDOW; n++) begin
            @(negedge clk_sys);
            if (soft_rst) begin
                high_cycles++;
            end
        end
        keys.reset = 1'b0;
        if (high_cycles == 0) begin
            $display("test 6: no soft_rst pulse within %0d cycles", PULSE_WINDOW);
            bench_fails++;
        end else if (high_cycles != 1) begin
            $display("test 6: soft_rst stayed high for %0d cycles", high_cycles);
            bench_fails++;
        end else begin
            $display("test 6 soft_rst pulse passed");
        end
    endtask

    initial begin
        void'($urandom(32'h5dddeb42));
        rst         = 1'b1;
        keys        = '0;
        en4way      = 1'b0;
        rot         = 1'b0;
        flip        = 1'b0;
        osd_pause   = 1'b0;
        downloading = 1'b0;
        check_req   = 1'b0;
        test_num    = 0;
        bench_fails = 0;
        for (int p = 0; p < PLAYERS; p++) begin
            board_joy[p] = '0;
        end
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
        settle(4);
        request_check(1);

        // Pass-through with random words
        for (int i = 0; i < 6; i++) begin
            random_sticks();
            settle(4);
            request_check(2);
        end

        // One direction per stick, both flip settings
        random_sticks();
        for (int p = 0; p < PLAYERS; p++) begin
            board_joy[p].dir = 4'b0001 << p;
        end
        rot = 1'b1;
        settle(4);
        request_check(3);
        flip = 1'b1;
        settle(4);
        request_check(3);
        rot  = 1'b0;
        flip = 1'b0;

        // Single, diagonal with it, then diagonal without it
        en4way = 1'b1;
        for (int p = 0; p < PLAYERS; p++) begin
            board_joy[p]     = '0;
            board_joy[p].dir = 4'b1000 >> p;
        end
        settle(4);
        request_check(4);
        for (int p = 0; p < PLAYERS; p++) begin
            board_joy[p].dir = board_joy[p].dir | {board_joy[p].dir[0], board_joy[p].dir[3:1]};
        end
        settle(4);
        request_check(4);
        for (int p = 0; p < PLAYERS; p++) begin
            board_joy[p].dir = ~board_joy[p].dir;
        end
        settle(4);
        request_check(4);
        en4way = 1'b0;
        for (int p = 0; p < PLAYERS; p++) begin
            board_joy[p] = '0;
        end

        // Pause from host key, player 2 button, menu level and download
        keys.pause = 1'b1;
        settle(4);
        keys.pause = 1'b0;
        settle(4);
        request_check(5);
        board_joy[1][PAUSE_BIT] = 1'b1;
        settle(4);
        board_joy[1][PAUSE_BIT] = 1'b0;
        settle(4);
        request_check(5);
        osd_pause = 1'b1;
        settle(4);
        request_check(5);
        osd_pause = 1'b0;
        settle(4);
        request_check(5);
        keys.pause = 1'b1;
        settle(2);
        keys.pause = 1'b0;
        settle(4);
        downloading = 1'b1;
        settle(4);
        request_check(5);
        downloading = 1'b0;
        settle(4);
        request_check(5);

        soft_reset_pulse();
        settle(4);
        request_check(6);
        for (int k = 0; k < 4; k++) begin
            keys.gfx[k] = 1'b1;
            settle(4);
            keys.gfx[k] = 1'b0;
            settle(4);
            request_check(6);
        end
        keys.service = 1'b1;
        settle(4);
        request_check(6);
        keys.service = 1'b0;
        settle(4);
        request_check(6);

        $display("%0d checks passed, %0d failed", checks_passed, checks_failed + bench_fails);
        if (checks_failed + bench_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/board_pkg.sv
hw/joy_4way.sv
hw/joy_map.sv
hw/board_ctrl.sv
hw/board_inputs.sv
bench/board_checker.sv
bench/tb_board_inputs.sv

// ==== hw/board_ctrl.sv ====
`timescale 1ns/1ps

/*
  Pause state, soft reset pulse, layer enables and service line.
  All host keys and joy_pause are active high levels. Edges are taken
  against a one-clock copy, so a key must stay low a clock to re-arm.
  An osd_pause change overrides a toggle seen in the same clock.
*/
module board_ctrl #(
    parameter int INPUTS_ACTIVE_LOW = 1
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  board_pkg::host_keys_t keys,
    input  logic                  joy_pause,
    input  logic                  osd_pause,
    input  logic                  downloading,
    output logic                  game_pause,
    output logic                  soft_rst,
    output logic [3:0]            gfx_en,
    output logic                  game_service
);
    import board_pkg::*;

    localparam bit INV = (INPUTS_ACTIVE_LOW != 0);

    host_keys_t keys_last;
    host_keys_t key_rise;
    logic       joy_pause_last;
    logic       osd_pause_last;
    logic       osd_change;
    logic       pause_toggle;

    // Previous-cycle copies for edge detection
    always_ff @(posedge clk_sys) begin
        keys_last      <= keys;
        joy_pause_last <= joy_pause;
        osd_pause_last <= osd_pause;
    end

    assign key_rise     = keys & ~keys_last;
    assign osd_change   = osd_pause ^ osd_pause_last;
    assign pause_toggle = key_rise.pause | (joy_pause & ~joy_pause_last);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
            gfx_en       <= 4'hf;
            game_service <= INV;
        end else begin
            // Download clears pause and a menu change beats a toggle
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_change) begin
                game_pause <= osd_pause;
            end else if (pause_toggle) begin
                game_pause <= ~game_pause;
            end

            soft_rst     <= key_rise.reset;
            gfx_en       <= gfx_en ^ key_rise.gfx;
            game_service <= keys.service ^ INV;
        end
    end

    // A key press gives a single-clock pulse
    assert property (@(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst)
        else $error("board_ctrl: soft_rst held for more than one cycle");

endmodule

// ==== hw/board_inputs.sv ====
`timescale 1ns/1ps

/*
  Player-input block of the board wrapper, all on clk_sys.
  Directions take 3 clocks to the game, buttons, coin and start take 2.
  Game outputs, coin, start and service idle high when INPUTS_ACTIVE_LOW is 1.
*/
module board_inputs #(
    parameter int BUTTONS           = 2,
    parameter int INPUTS_ACTIVE_LOW = 1
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  board_pkg::board_joy_t board_joy [board_pkg::PLAYERS],
    input  board_pkg::host_keys_t keys,
    input  logic                  en4way,
    input  logic                  rot,
    input  logic                  flip,
    input  logic                  osd_pause,
    input  logic                  downloading,
    output board_pkg::game_joy_t  game_joy  [board_pkg::PLAYERS],
    output logic [3:0]            game_coin,
    output logic [3:0]            game_start,
    output logic                  game_pause,
    output logic                  soft_rst,
    output logic                  game_service,
    output logic [3:0]            gfx_en
);
    import board_pkg::*;

    logic [3:0] dir4 [PLAYERS];
    logic       joy_pause;

    // One filter per stick
    for (genvar i = 0; i < PLAYERS; i++) begin : g_filter
        joy_4way u_joy_4way (
            .clk_sys ( clk_sys          ),
            .rst     ( rst              ),
            .enable  ( en4way           ),
            .joy8    ( board_joy[i].dir ),
            .joy4    ( dir4[i]          )
        );
    end

    joy_map #(
        .BUTTONS           ( BUTTONS           ),
        .INPUTS_ACTIVE_LOW ( INPUTS_ACTIVE_LOW )
    ) u_joy_map (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .board_joy  ( board_joy  ),
        .dir4       ( dir4       ),
        .rot        ( rot        ),
        .flip       ( flip       ),
        .game_joy   ( game_joy   ),
        .game_coin  ( game_coin  ),
        .game_start ( game_start ),
        .joy_pause  ( joy_pause  )
    );

    board_ctrl #(
        .INPUTS_ACTIVE_LOW ( INPUTS_ACTIVE_LOW )
    ) u_board_ctrl (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .keys         ( keys         ),
        .joy_pause    ( joy_pause    ),
        .osd_pause    ( osd_pause    ),
        .downloading  ( downloading  ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     ),
        .gfx_en       ( gfx_en       ),
        .game_service ( game_service )
    );

endmodule

// ==== hw/board_pkg.sv ====
/*
  Shared types for the player-input block.
  Stick words are active high on the board side. Polarity towards the game
  is chosen by the top-level parameter, not here.
*/
package board_pkg;

    // Four player sticks on every board
    localparam int PLAYERS = 4;

    // Board stick word
    // btn holds buttons, start, coin and pause at positions set by BUTTONS
    // dir is up, down, left, right from bit 3 down to bit 0
    typedef struct packed {
        logic [11:0] btn;
        logic [3:0]  dir;
    } board_joy_t;

    // Word presented to the game core
    typedef struct packed {
        logic [5:0] btn;
        logic [3:0] dir;
    } game_joy_t;

    // Host-side keys, all active high
    typedef struct packed {
        logic       pause;
        logic       reset;
        logic       service;
        logic [3:0] gfx;
    } host_keys_t;

    // Direction currently held by the 4-way filter
    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_sel_e;

endpackage

// ==== hw/joy_4way.sv ====
`timescale 1ns/1ps

/*
  4-way filter for one stick. joy4 is registered and trails joy8 by a clock.
  With enable low the stick passes through unfiltered.
  A diagonal keeps the held direction only while that direction stays pressed.
*/
module joy_4way (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       enable,
    input  logic [3:0] joy8,
    output logic [3:0] joy4
);
    import board_pkg::*;

    dir_sel_e held;
    dir_sel_e held_next;

    // One-hot stick bits for a held direction
    function automatic logic [3:0] dir_bits(input dir_sel_e sel);
        case (sel)
            DIR_UP:    return 4'b1000;
            DIR_DOWN:  return 4'b0100;
            DIR_LEFT:  return 4'b0010;
            DIR_RIGHT: return 4'b0001;
            default:   return 4'b0000;
        endcase
    endfunction

    // A single press wins outright and a diagonal keeps the held direction
    always_comb begin
        case (joy8)
            4'b1000: held_next = DIR_UP;
            4'b0100: held_next = DIR_DOWN;
            4'b0010: held_next = DIR_LEFT;
            4'b0001: held_next = DIR_RIGHT;
            4'b0000: held_next = DIR_NONE;
            default: begin
                if (|(dir_bits(held) & joy8)) begin
                    held_next = held;
                end else begin
                    held_next = DIR_NONE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            held <= DIR_NONE;
            joy4 <= 4'b0000;
        end else if (enable) begin
            held <= held_next;
            joy4 <= dir_bits(held_next);
        end else begin
            // Filter off so no direction is held
            held <= DIR_NONE;
            joy4 <= joy8;
        end
    end

    // Output reflects enable and joy8 one clock late
    assert property (@(posedge clk_sys) disable iff (rst)
        $past(enable) |-> $onehot0(joy4) && ((joy4 & ~$past(joy8)) == 4'b0000))
        else $error("joy_4way: joy4=%h is not a single pressed direction", joy4);

endmodule

// ==== hw/joy_map.sv ====
`timescale 1ns/1ps

/*
  Stick mapper for all players: one sampling stage, then rotation, polarity
  and the coin/start gather. BUTTONS must stay within 2..9 so the pause bit
  fits the 16-bit stick word. Only the low six btn bits reach the game.
*/
module joy_map #(
    parameter int BUTTONS           = 2,
    parameter int INPUTS_ACTIVE_LOW = 1
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  board_pkg::board_joy_t board_joy [board_pkg::PLAYERS],
    input  logic [3:0]            dir4      [board_pkg::PLAYERS],
    input  logic                  rot,
    input  logic                  flip,
    output board_pkg::game_joy_t  game_joy  [board_pkg::PLAYERS],
    output logic [3:0]            game_coin,
    output logic [3:0]            game_start,
    output logic                  joy_pause
);
    import board_pkg::*;

    // Special bit positions in the full stick word
    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);

    localparam bit INV = (INPUTS_ACTIVE_LOW != 0);

    localparam int GAME_W = $bits(game_joy_t);

    board_joy_t joy_sync [PLAYERS];
    game_joy_t  joy_rot  [PLAYERS];

    // Vertical screen remap in up, down, left, right bit order
    function automatic logic [3:0] rotate_dir(
        input logic [3:0] dir,
        input logic       rot_en,
        input logic       flip_en
    );
        if (!rot_en) begin
            return dir;
        end else if (flip_en) begin
            return {dir[1], dir[0], dir[2], dir[3]};
        end else begin
            return {dir[0], dir[1], dir[3], dir[2]};
        end
    endfunction

    // Sampling stage with directions from the filters
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < PLAYERS; i++) begin
            joy_sync[i] <= {board_joy[i].btn, dir4[i]};
        end
    end

    always_comb begin
        for (int i = 0; i < PLAYERS; i++) begin
            joy_rot[i].btn = joy_sync[i].btn[5:0];
            joy_rot[i].dir = rotate_dir(joy_sync[i].dir, rot, flip);
        end
    end

    // Game side idle level depends on polarity
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < PLAYERS; i++) begin
                game_joy[i] <= {GAME_W{INV}};
            end
            game_coin  <= {4{INV}};
            game_start <= {4{INV}};
            joy_pause  <= 1'b0;
        end else begin
            for (int i = 0; i < PLAYERS; i++) begin
                game_joy[i]   <= joy_rot[i] ^ {GAME_W{INV}};
                game_coin[i]  <= joy_sync[i][COIN_BIT] ^ INV;
                game_start[i] <= joy_sync[i][START_BIT] ^ INV;
            end
            // Only players 1 and 2 carry a pause button
            joy_pause <= joy_sync[0][PAUSE_BIT] | joy_sync[1][PAUSE_BIT];
        end
    end

endmodule
